// File: Makefile
TOP = macro_fetch_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps -f tb.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "result: fail"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "result: no verdict"; exit 1; fi
	@echo "result: pass"

clean:
	rm -rf obj_dir $(LOG)

// File: sim/macro_fetch_tb.sv
//////////////////////////////////////////////////////////////////////
// expected values follow the LC and fetch rules; memory latency is
// random 1 to 4 cycles, and each command waits for instr.valid.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "macro_fetch_macros.svh"

module macro_fetch_tb;

   localparam int NUM_ROWS        = 15;
   localparam int RESET_CYCLES    = 16;
   localparam int CLK_PERIOD      = 20;
   localparam int WATCHDOG_CYCLES = NUM_ROWS * 20 + RESET_CYCLES;

   logic                        clk;
   logic                        reset;
   macro_fetch_pkg::lc_cmd_t    cmd;
   macro_fetch_pkg::mem_rsp_t   mem_rsp;
   logic                        ext_int;
   macro_fetch_pkg::mem_req_t   mem_req;
   macro_fetch_pkg::instr_out_t instr;
   logic                        sintr;

   string                    row_name  [NUM_ROWS];
   macro_fetch_pkg::lc_cmd_e row_op    [NUM_ROWS];
   logic                     row_bm    [NUM_ROWS];
   logic [`LC_WIDTH-1:0]     row_lc    [NUM_ROWS];
   logic                     row_int   [NUM_ROWS];
   logic [`INSTR_WIDTH-1:0]  exp_instr [NUM_ROWS];
   logic [`LC_WIDTH-1:0]     exp_lc    [NUM_ROWS];
   logic                     exp_fetch [NUM_ROWS];

   int rows_added;
   int mismatches;
   int failed_tests;
   int test_errors;

   macro_fetch_unit macro_fetch_unit_i
   (
      .clk     (clk),
      .reset   (reset),
      .cmd     (cmd),
      .mem_rsp (mem_rsp),
      .ext_int (ext_int),
      .mem_req (mem_req),
      .instr   (instr),
      .sintr   (sintr)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #(CLK_PERIOD / 2) clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////

   // memory contents, a hash of the word address.
   function automatic logic [`WORD_WIDTH-1:0] mem_word(input logic [`ADDR_WIDTH-1:0] addr);
      logic [63:0] product;
      product = {40'd0, addr} * 64'h9E3779B1;
      return product[31:0];
   endfunction

   // byte lc[1:0] or halfword lc[1] of the addressed word.
   function automatic logic [`INSTR_WIDTH-1:0] pick_instr(input logic [`LC_WIDTH-1:0] lc,
                                                          input logic byte_mode);
      logic [`WORD_WIDTH-1:0] w;
      w = mem_word(lc[`LC_WIDTH-1:2]);
      if (byte_mode)
      begin
         case (lc[1:0])
            2'd0:    return {8'd0, w[7:0]};
            2'd1:    return {8'd0, w[15:8]};
            2'd2:    return {8'd0, w[23:16]};
            default: return {8'd0, w[31:24]};
         endcase
      end
      if (lc[1])
         return w[31:16];
      return w[15:0];
   endfunction

   task automatic add_row(input string name, input macro_fetch_pkg::lc_cmd_e op,
                          input logic bm, input logic [`LC_WIDTH-1:0] lc, input logic irq);
      row_name[rows_added] = name;
      row_op[rows_added]   = op;
      row_bm[rows_added]   = bm;
      row_lc[rows_added]   = lc;
      row_int[rows_added]  = irq;
      rows_added++;
   endtask

   // walks the table with a model LC to fill the expected columns.
   task automatic predict_rows();
      logic [`LC_WIDTH-1:0] model_lc;
      logic [`LC_WIDTH-1:0] step;
      logic                 model_bm;
      model_lc = '0;
      model_bm = 1'b0;
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         if (row_op[i] == macro_fetch_pkg::LC_LOAD)
         begin
            exp_fetch[i] = 1'b1;                   // new LC, word unknown.
            model_lc     = row_lc[i];
            model_bm     = row_bm[i];
         end
         else
         begin
            exp_fetch[i] = model_bm ? (model_lc[1:0] == 2'b11) : model_lc[1];
            step         = '0;
            step[1:0]    = model_bm ? 2'd1 : 2'd2;
            model_lc     = model_lc + step;
         end
         exp_lc[i]    = model_lc;
         exp_instr[i] = pick_instr(model_lc, model_bm);
      end
   endtask

   task automatic check_value(input string name, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h",
                  name, what, expected, actual);
         mismatches++;
         test_errors++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // memory model, one answer per request
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      logic [`ADDR_WIDTH-1:0] addr;
      int                     wait_cycles;
      void'($urandom(17));
      mem_rsp = '0;
      forever
      begin
         @(negedge clk);
         if (!reset && mem_req.valid)
         begin
            addr        = mem_req.addr;
            wait_cycles = 1 + int'($urandom % 4);  // 1 to 4 cycles.
            repeat (wait_cycles) @(posedge clk);
            #2;
            mem_rsp.data  = mem_word(addr);
            mem_rsp.valid = 1'b1;
            @(posedge clk);
            #2;
            mem_rsp.valid = 1'b0;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus and checks
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      int                     n;
      int                     reqs;
      int                     rsp_n;
      logic [`ADDR_WIDTH-1:0] req_addr;
      logic                   got;
      reset        = 1'b1;
      cmd          = '0;
      ext_int      = 1'b0;
      rows_added   = 0;
      mismatches   = 0;
      failed_tests = 0;

      add_row("load_half_low",    macro_fetch_pkg::LC_LOAD, 1'b0, 26'h001230,  1'b0);
      add_row("next_upper_half",  macro_fetch_pkg::LC_NEXT, 1'b0, 26'h000000,  1'b1);
      add_row("next_cross_word",  macro_fetch_pkg::LC_NEXT, 1'b0, 26'h000000,  1'b0);
      add_row("load_half_upper",  macro_fetch_pkg::LC_LOAD, 1'b0, 26'h020006,  1'b1);
      add_row("reload_same_word", macro_fetch_pkg::LC_LOAD, 1'b0, 26'h020004,  1'b0);
      add_row("load_byte_0",      macro_fetch_pkg::LC_LOAD, 1'b1, 26'h034560,  1'b1);
      add_row("next_byte_1",      macro_fetch_pkg::LC_NEXT, 1'b0, 26'h000000,  1'b0);
      add_row("next_byte_2",      macro_fetch_pkg::LC_NEXT, 1'b0, 26'h000000,  1'b1);
      add_row("next_byte_3",      macro_fetch_pkg::LC_NEXT, 1'b0, 26'h000000,  1'b1);
      add_row("next_byte_cross",  macro_fetch_pkg::LC_NEXT, 1'b0, 26'h000000,  1'b0);
      add_row("next_byte_after",  macro_fetch_pkg::LC_NEXT, 1'b0, 26'h000000,  1'b1);
      add_row("load_top_word",    macro_fetch_pkg::LC_LOAD, 1'b0, 26'h3FFFFFE, 1'b0);
      add_row("next_wrap",        macro_fetch_pkg::LC_NEXT, 1'b0, 26'h000000,  1'b1);
      add_row("load_byte_3",      macro_fetch_pkg::LC_LOAD, 1'b1, 26'hABCDE7,  1'b0);
      add_row("next_byte_wrap",   macro_fetch_pkg::LC_NEXT, 1'b0, 26'h000000,  1'b1);
      predict_rows();

      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      reset = 1'b0;

      for (int i = 0; i < NUM_ROWS; i++)
      begin
         test_errors = 0;
         @(posedge clk);
         #2;
         cmd.valid     = 1'b1;
         cmd.op        = row_op[i];
         cmd.byte_mode = row_bm[i];
         cmd.load_lc   = row_lc[i];
         ext_int       = row_int[i];
         @(posedge clk);
         #2;
         cmd.valid = 1'b0;
         ext_int   = ~row_int[i];              // sintr keeps the sampled value.

         // n is the cycle count since the command cycle.
         n        = 1;
         reqs     = 0;
         rsp_n    = -1;
         req_addr = '0;
         got      = 1'b0;
         while (!got)
         begin
            @(negedge clk);
            if (mem_req.valid)
            begin
               reqs++;
               req_addr = mem_req.addr;
            end
            if (mem_rsp.valid)
               rsp_n = n;
            if (instr.valid)
               got = 1'b1;
            else
               n++;
         end

         check_value(row_name[i], "instr", 32'(exp_instr[i]), 32'(instr.instr));
         check_value(row_name[i], "lc", 32'(exp_lc[i]), 32'(instr.lc));
         check_value(row_name[i], "requests", 32'(exp_fetch[i]), reqs);
         check_value(row_name[i], "sintr", 32'(row_int[i]), 32'(sintr));
         if (exp_fetch[i])
         begin
            check_value(row_name[i], "req addr", 32'(exp_lc[i][`LC_WIDTH-1:2]),
                        32'(req_addr));
            check_value(row_name[i], "cycles after rsp", 32'd1, n - rsp_n);
         end
         else
            check_value(row_name[i], "cycles after cmd", 32'd2, n);

         if (test_errors == 0)
            $display("test %s: ok", row_name[i]);
         else
         begin
            $display("test %s: %0d mismatches", row_name[i], test_errors);
            failed_tests++;
         end
      end

      $display("tests %0d, failed %0d, mismatches %0d", NUM_ROWS, failed_tests, mismatches);
      if (mismatches == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

   // covers the slowest fetch of every row with room to spare.
   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired, instr.valid did not come for the current command");
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
+incdir+verilog
verilog/macro_fetch_pkg.sv
verilog/lc_control.sv
verilog/location_counter.sv
verilog/word_fetcher.sv
verilog/instruction_rotator.sv
verilog/macro_fetch_unit.sv
sim/macro_fetch_tb.sv

// File: verilog/instruction_rotator.sv
//////////////////////////////////////////////////////////////////////
// byte order in the word is by lc[1:0], byte 0 in bits 7:0.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "macro_fetch_macros.svh"

module instruction_rotator
(
   input  wire                        clk,
   input  wire                        reset,
   input  wire [`WORD_WIDTH-1:0]      word,
   input  wire                        sh4,
   input  wire                        sh3,
   input  wire                        lc_byte_mode,
   input  wire [`LC_WIDTH-1:0]        lc,
   input  wire                        emit,
   input  wire                        word_ready,
   output macro_fetch_pkg::instr_out_t instr
);

   logic [`WORD_WIDTH-1:0]  rot16;
   logic [`WORD_WIDTH-1:0]  rot8;
   logic [`INSTR_WIDTH-1:0] sel;
   logic                    load;
   logic                    valid_q;
   logic [`INSTR_WIDTH-1:0] instr_q;
   logic [`LC_WIDTH-1:0]    lc_q;

   // rotate right by a halfword, then by a byte.
   assign rot16 = sh4 ? {word[`INSTR_WIDTH-1:0], word[`WORD_WIDTH-1:`INSTR_WIDTH]} : word;
   assign rot8  = sh3 ? {rot16[7:0], rot16[`WORD_WIDTH-1:8]} : rot16;
   assign sel   = lc_byte_mode ? {{(`INSTR_WIDTH-8){1'b0}}, rot8[7:0]}
                               : rot8[`INSTR_WIDTH-1:0];

   assign load = emit | word_ready;

   always_ff @(posedge clk)
   begin
      if (reset)
         valid_q <= 1'b0;
      else
         valid_q <= load;
   end

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         instr_q <= sel;
         lc_q    <= lc;              // LC already points here.
      end
   end

   assign instr = '{valid: valid_q, instr: instr_q, lc: lc_q};

endmodule

`default_nettype wire

// File: verilog/lc_control.sv
//////////////////////////////////////////////////////////////////////
// one command in flight; commands while busy are dropped, and LC_NEXT
// before the first LC_LOAD is dropped too.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "macro_fetch_macros.svh"

module lc_control
(
   input  wire                           clk,
   input  wire                           reset,
   input  wire macro_fetch_pkg::lc_cmd_t cmd,
   input  wire [`LC_WIDTH-1:0]           lc,
   input  wire                           lc_byte_mode,
   input  wire                           word_ready,
   input  wire                           ext_int,
   output logic                          lcinc,
   output logic                          destlc,
   output logic                          fetch_start,
   output logic                          emit,
   output logic                          sh4,
   output logic                          sh3,
   output logic                          sintr
);

   logic is_load;
   logic is_next;
   logic accept;
   logic loaded;            // a load has been seen since reset.
   logic busy;
   logic newlc;
   logic lc0b;
   logic have_wrong_word;
   logic last_byte_in_word;
   logic need_fetch;

   //////////////////////////////////////////////////////////////////////
   // command decode
   //////////////////////////////////////////////////////////////////////

   assign is_load = (cmd.op == macro_fetch_pkg::LC_LOAD);
   assign is_next = (cmd.op == macro_fetch_pkg::LC_NEXT);
   assign accept  = cmd.valid & ~busy & (is_load | (is_next & loaded));

   assign destlc = accept & is_load;
   assign lcinc  = accept & is_next;

   //////////////////////////////////////////////////////////////////////
   // fetch decision, taken on the old LC
   //////////////////////////////////////////////////////////////////////

   assign lc0b              = lc[0] & lc_byte_mode;
   assign have_wrong_word   = newlc | destlc;
   assign last_byte_in_word = lc[1] & (lc0b | ~lc_byte_mode); // last slot of word.
   assign need_fetch        = have_wrong_word | last_byte_in_word;

   // rotate selects follow the new LC.
   assign sh4 = lc[1];
   assign sh3 = lc0b;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         loaded      <= 1'b0;
         busy        <= 1'b0;
         newlc       <= 1'b0;
         fetch_start <= 1'b0;
         emit        <= 1'b0;
         sintr       <= 1'b0;
      end
      else
      begin
         fetch_start <= accept & need_fetch;
         emit        <= accept & ~need_fetch;
         if (destlc)
            loaded <= 1'b1;
         if (accept)
            busy <= 1'b1;
         else if (emit | word_ready)
            busy <= 1'b0;                 // instruction goes out now.
         if (destlc)
            newlc <= 1'b1;
         else if (word_ready)
            newlc <= 1'b0;                // right word is in.
         if (accept)
            sintr <= ext_int;             // sampled per command.
      end
   end

   //////////////////////////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////////////////////////

   // the source must wait for instr.valid before the next command.
   assert property (@(posedge clk) disable iff (reset) cmd.valid |-> !busy)
      else $error("lc_control: command while busy");

   // a fetched word and a direct emit never load the rotator together.
   assert property (@(posedge clk) disable iff (reset) !(word_ready && emit))
      else $error("lc_control: word_ready and emit together");

   assert property (@(posedge clk) disable iff (reset) (cmd.valid && is_next) |-> loaded)
      else $error("lc_control: LC_NEXT before any LC_LOAD");

endmodule

`default_nettype wire

// File: verilog/location_counter.sv
//////////////////////////////////////////////////////////////////////
// byte address LC; a load wins over an increment in the same cycle.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "macro_fetch_macros.svh"

module location_counter
(
   input  wire                   clk,
   input  wire                   reset,
   input  wire                   destlc,
   input  wire                   lcinc,
   input  wire [`LC_WIDTH-1:0]   load_lc,
   input  wire                   byte_mode_in,
   output logic [`LC_WIDTH-1:0]  lc,
   output logic                  lc_byte_mode
);

   logic [1:0]           step;
   logic [`LC_WIDTH-1:0] lc_next;

   // byte mode walks bytes, halfword mode walks halfwords.
   assign step    = lc_byte_mode ? 2'd1 : 2'd2;
   assign lc_next = lc + {{(`LC_WIDTH-2){1'b0}}, step};

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         lc           <= '0;
         lc_byte_mode <= 1'b0;
      end
      else if (destlc)
      begin
         lc           <= load_lc;
         lc_byte_mode <= byte_mode_in;     // mode only changes on load.
      end
      else if (lcinc)
      begin
         lc <= lc_next;
      end
   end

   // halfword mode never points at an odd byte.
   assert property (@(posedge clk) disable iff (reset) !lc_byte_mode |-> !lc[0])
      else $error("location_counter: odd LC in halfword mode");

endmodule

`default_nettype wire

// File: verilog/macro_fetch_macros.svh
//////////////////////////////////////////////////////////////////////
// widths for the macro fetch path; LC is a byte address and the
// word address drops its two low bits, so ADDR_WIDTH tracks LC_WIDTH.
//////////////////////////////////////////////////////////////////////

`ifndef MACRO_FETCH_MACROS_SVH
`define MACRO_FETCH_MACROS_SVH

// byte address held in the location counter.
`define LC_WIDTH 26

// one main memory word, four bytes.
`define WORD_WIDTH 32

// a macro-instruction is one halfword.
`define INSTR_WIDTH 16

// word address sent to memory, LC without lc[1:0].
`define ADDR_WIDTH 24

`endif

// File: verilog/macro_fetch_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared types of the macro fetch path; every valid is a 1-cycle strobe.
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "macro_fetch_macros.svh"

package macro_fetch_pkg;

   // LC_NEXT steps the LC, LC_LOAD jumps to a new one.
   typedef enum logic [1:0]
   {
      LC_NOP  = 2'd0,
      LC_NEXT = 2'd1,
      LC_LOAD = 2'd2
   } lc_cmd_e;

   typedef struct packed
   {
      logic                 valid;
      lc_cmd_e              op;
      logic                 byte_mode; // mode taken on load only.
      logic [`LC_WIDTH-1:0] load_lc;
   } lc_cmd_t;

   typedef struct packed
   {
      logic                   valid;
      logic [`ADDR_WIDTH-1:0] addr;
   } mem_req_t;

   typedef struct packed
   {
      logic                   valid;
      logic [`WORD_WIDTH-1:0] data;
   } mem_rsp_t;

   typedef struct packed
   {
      logic                    valid;
      logic [`INSTR_WIDTH-1:0] instr;
      logic [`LC_WIDTH-1:0]    lc;     // LC of this instruction.
   } instr_out_t;

endpackage

`default_nettype wire

// File: verilog/macro_fetch_unit.sv
//////////////////////////////////////////////////////////////////////
// no back-pressure on either side; start with LC_LOAD after reset,
// then wait for instr.valid before each following command.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "macro_fetch_macros.svh"

module macro_fetch_unit
(
   input  wire                            clk,
   input  wire                            reset,
   input  wire macro_fetch_pkg::lc_cmd_t  cmd,
   input  wire macro_fetch_pkg::mem_rsp_t mem_rsp,
   input  wire                            ext_int,
   output macro_fetch_pkg::mem_req_t      mem_req,
   output macro_fetch_pkg::instr_out_t    instr,
   output logic                           sintr
);

   logic [`LC_WIDTH-1:0]   lc;
   logic                   lc_byte_mode;
   logic                   lcinc;
   logic                   destlc;
   logic                   fetch_start;
   logic                   emit;
   logic                   sh4;
   logic                   sh3;
   logic                   word_ready;
   logic [`WORD_WIDTH-1:0] word;

   lc_control lc_control_i
   (
      .clk          (clk),
      .reset        (reset),
      .cmd          (cmd),
      .lc           (lc),
      .lc_byte_mode (lc_byte_mode),
      .word_ready   (word_ready),
      .ext_int      (ext_int),
      .lcinc        (lcinc),
      .destlc       (destlc),
      .fetch_start  (fetch_start),
      .emit         (emit),
      .sh4          (sh4),
      .sh3          (sh3),
      .sintr        (sintr)
   );

   location_counter location_counter_i
   (
      .clk          (clk),
      .reset        (reset),
      .destlc       (destlc),
      .lcinc        (lcinc),
      .load_lc      (cmd.load_lc),
      .byte_mode_in (cmd.byte_mode),
      .lc           (lc),
      .lc_byte_mode (lc_byte_mode)
   );

   word_fetcher word_fetcher_i
   (
      .clk         (clk),
      .reset       (reset),
      .fetch_start (fetch_start),
      .lc          (lc),
      .mem_rsp     (mem_rsp),
      .mem_req     (mem_req),
      .word        (word),
      .word_ready  (word_ready)
   );

   instruction_rotator instruction_rotator_i
   (
      .clk          (clk),
      .reset        (reset),
      .word         (word),
      .sh4          (sh4),
      .sh3          (sh3),
      .lc_byte_mode (lc_byte_mode),
      .lc           (lc),
      .emit         (emit),
      .word_ready   (word_ready),
      .instr        (instr)
   );

endmodule

`default_nettype wire

// File: verilog/word_fetcher.sv
//////////////////////////////////////////////////////////////////////
// one word read in flight at a time; memory answers once per request.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "macro_fetch_macros.svh"

module word_fetcher
(
   input  wire                            clk,
   input  wire                            reset,
   input  wire                            fetch_start,
   input  wire [`LC_WIDTH-1:0]            lc,
   input  wire macro_fetch_pkg::mem_rsp_t mem_rsp,
   output macro_fetch_pkg::mem_req_t      mem_req,
   output logic [`WORD_WIDTH-1:0]         word,
   output logic                           word_ready
);

   typedef enum logic
   {
      FETCH_IDLE = 1'b0,
      FETCH_WAIT = 1'b1
   } fetch_state_e;

   fetch_state_e           state;
   logic                   take;
   logic [`WORD_WIDTH-1:0] word_q;

   // request goes out in the fetch_start cycle.
   assign mem_req = '{valid: fetch_start & (state == FETCH_IDLE),
                      addr:  lc[`LC_WIDTH-1:2]};

   assign take       = mem_rsp.valid & (state == FETCH_WAIT);
   assign word_ready = take;
   assign word       = take ? mem_rsp.data : word_q; // bypass on arrival.

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= FETCH_IDLE;
      else
      begin
         case (state)
            FETCH_IDLE:
            begin
               if (fetch_start)
                  state <= FETCH_WAIT;
            end
            FETCH_WAIT:
            begin
               if (mem_rsp.valid)
                  state <= FETCH_IDLE;
            end
            default:
               state <= FETCH_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (take)
         word_q <= mem_rsp.data;       // held for later halfwords.
   end

   // memory only answers a request we made.
   assert property (@(posedge clk) disable iff (reset)
                    mem_rsp.valid |-> (state == FETCH_WAIT))
      else $error("word_fetcher: response while idle");

endmodule

`default_nettype wire
